// ==== logic/soc_pkg.sv ====
package soc_pkg;

	// ==================================================================
	// Bus widths
	// ==================================================================

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int LED_W = 10;

	// Byte address to word index
	localparam int WORD_LSB = 2;

	// On-chip RAM depth and index width
	localparam int RAM_WORDS = 1024;
	localparam int RAM_AW = $clog2(RAM_WORDS);

	// ==================================================================
	// Address map
	// ==================================================================

	localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0001_0000;
	localparam logic [ADDR_W-1:0] RAM_LIMIT = 32'h0001_1000;

	localparam logic [ADDR_W-1:0] LED_BASE = 32'h5000_0000;
	localparam logic [ADDR_W-1:0] LED_LIMIT = 32'h5000_0010;

	// Everything from here up goes to the timer
	localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h6000_0000;

	// ==================================================================
	// Types
	// ==================================================================

	typedef enum logic
	{
		OP_READ = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_e;

	// Decoded target of the shared bus
	typedef enum logic [1:0]
	{
		SEL_RAM = 2'd0,
		SEL_LED = 2'd1,
		SEL_TIMER = 2'd2,
		SEL_NONE = 2'd3
	} slave_sel_e;

	// Port A is the instruction port, port B the data port
	typedef enum logic [1:0]
	{
		ARB_IDLE = 2'd0,
		ARB_PORT_A = 2'd1,
		ARB_PORT_B = 2'd2
	} arb_state_e;

endpackage

// ==== logic/soc_bus_if.sv ====
`timescale 1ns/1ps

interface soc_bus_if;

	logic request;
	soc_pkg::bus_op_e rw;
	logic [soc_pkg::ADDR_W-1:0] address;
	logic [soc_pkg::DATA_W-1:0] wdata;
	logic [soc_pkg::DATA_W-1:0] rdata;
	logic ready;

	// Request side
	modport master
	(
		output request,
		output rw,
		output address,
		output wdata,
		input rdata,
		input ready
	);

	// Responding side
	modport slave
	(
		input request,
		input rw,
		input address,
		input wdata,
		output rdata,
		output ready
	);

endinterface

// ==== logic/bus_access.sv ====
`timescale 1ns/1ps

module bus_access
(
	input logic clock,
	input logic i_rst_n,

	// Instruction port, read only
	input logic i_ia_request,
	input logic [soc_pkg::ADDR_W-1:0] i_ia_address,
	output logic o_ia_ready,
	output logic [soc_pkg::DATA_W-1:0] o_ia_rdata,

	// Data port
	input logic i_db_request,
	input soc_pkg::bus_op_e i_db_rw,
	input logic [soc_pkg::ADDR_W-1:0] i_db_address,
	input logic [soc_pkg::DATA_W-1:0] i_db_wdata,
	output logic o_db_ready,
	output logic [soc_pkg::DATA_W-1:0] o_db_rdata,

	soc_bus_if.master sys_bus
);

	soc_pkg::arb_state_e state;
	logic ia_waiting;
	logic grant_ia;
	logic grant_db;

	// Grant decision, data port first unless the instruction port lost last time
	always_comb
	begin
		grant_ia = 1'b0;
		grant_db = 1'b0;
		if (state == soc_pkg::ARB_IDLE)
		begin
			if (ia_waiting && i_ia_request)
				grant_ia = 1'b1;
			else if (i_db_request)
				grant_db = 1'b1;
			else if (i_ia_request)
				grant_ia = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= soc_pkg::ARB_IDLE;
			sys_bus.request <= 1'b0;
			ia_waiting <= 1'b0;
		end
		else
		begin
			case (state)
				soc_pkg::ARB_IDLE:
				begin
					if (grant_db)
					begin
						state <= soc_pkg::ARB_PORT_B;
						sys_bus.request <= 1'b1;
						// Instruction port goes next if it was also asking
						ia_waiting <= i_ia_request;
					end
					else if (grant_ia)
					begin
						state <= soc_pkg::ARB_PORT_A;
						sys_bus.request <= 1'b1;
						ia_waiting <= 1'b0;
					end
				end
				soc_pkg::ARB_PORT_A, soc_pkg::ARB_PORT_B:
				begin
					if (sys_bus.ready)
					begin
						state <= soc_pkg::ARB_IDLE;
						sys_bus.request <= 1'b0;
					end
				end
				default:
				begin
					state <= soc_pkg::ARB_IDLE;
					sys_bus.request <= 1'b0;
				end
			endcase
		end
	end

	// Latch the granted port's transfer
	always_ff @(posedge clock)
	begin
		if (grant_db)
		begin
			sys_bus.rw <= i_db_rw;
			sys_bus.address <= i_db_address;
			sys_bus.wdata <= i_db_wdata;
		end
		else if (grant_ia)
		begin
			sys_bus.rw <= soc_pkg::OP_READ;
			sys_bus.address <= i_ia_address;
		end
	end

	assign o_ia_ready = (state == soc_pkg::ARB_PORT_A) && sys_bus.ready;
	assign o_ia_rdata = (state == soc_pkg::ARB_PORT_A) ? sys_bus.rdata : '0;
	assign o_db_ready = (state == soc_pkg::ARB_PORT_B) && sys_bus.ready;
	assign o_db_rdata = (state == soc_pkg::ARB_PORT_B) ? sys_bus.rdata : '0;

endmodule

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder
(
	soc_bus_if.slave sys_bus,
	soc_bus_if.master ram_bus,
	soc_bus_if.master led_bus,
	soc_bus_if.master timer_bus
);

	soc_pkg::slave_sel_e sel;

	// ==================================================================
	// Address decode
	// ==================================================================

	always_comb
	begin
		if (sys_bus.address >= soc_pkg::RAM_BASE && sys_bus.address < soc_pkg::RAM_LIMIT)
			sel = soc_pkg::SEL_RAM;
		else if (sys_bus.address >= soc_pkg::LED_BASE && sys_bus.address < soc_pkg::LED_LIMIT)
			sel = soc_pkg::SEL_LED;
		else if (sys_bus.address >= soc_pkg::TIMER_BASE)
			sel = soc_pkg::SEL_TIMER;
		else
			sel = soc_pkg::SEL_NONE;
	end

	// Request only reaches the selected slave
	assign ram_bus.request = sys_bus.request && (sel == soc_pkg::SEL_RAM);
	assign ram_bus.rw = sys_bus.rw;
	assign ram_bus.address = sys_bus.address - soc_pkg::RAM_BASE;
	assign ram_bus.wdata = sys_bus.wdata;

	assign led_bus.request = sys_bus.request && (sel == soc_pkg::SEL_LED);
	assign led_bus.rw = sys_bus.rw;
	assign led_bus.address = sys_bus.address - soc_pkg::LED_BASE;
	assign led_bus.wdata = sys_bus.wdata;

	assign timer_bus.request = sys_bus.request && (sel == soc_pkg::SEL_TIMER);
	assign timer_bus.rw = sys_bus.rw;
	assign timer_bus.address = sys_bus.address - soc_pkg::TIMER_BASE;
	assign timer_bus.wdata = sys_bus.wdata;

	// ==================================================================
	// Return path
	// ==================================================================

	always_comb
	begin
		case (sel)
			soc_pkg::SEL_RAM:
			begin
				sys_bus.rdata = ram_bus.rdata;
				sys_bus.ready = ram_bus.ready;
			end
			soc_pkg::SEL_LED:
			begin
				sys_bus.rdata = led_bus.rdata;
				sys_bus.ready = led_bus.ready;
			end
			soc_pkg::SEL_TIMER:
			begin
				sys_bus.rdata = timer_bus.rdata;
				sys_bus.ready = timer_bus.ready;
			end
			default:
			begin
				// Nothing mapped here, answer at once with zero
				sys_bus.rdata = '0;
				sys_bus.ready = sys_bus.request;
			end
		endcase
	end

endmodule

// ==== logic/block_ram.sv ====
`timescale 1ns/1ps

module block_ram
(
	input logic clock,
	input logic i_rst_n,
	soc_bus_if.slave mem_bus
);

	logic [soc_pkg::DATA_W-1:0] mem [soc_pkg::RAM_WORDS];
	logic [soc_pkg::RAM_AW-1:0] word_index;
	logic access;

	// Low address bits only, the decoder already removed the base
	assign word_index = mem_bus.address[soc_pkg::WORD_LSB +: soc_pkg::RAM_AW];

	// One access per request, skipped in the ready cycle
	assign access = mem_bus.request && !mem_bus.ready;

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			mem_bus.ready <= 1'b0;
		else
			mem_bus.ready <= access;
	end

	// Storage and read data
	always_ff @(posedge clock)
	begin
		if (access)
		begin
			if (mem_bus.rw == soc_pkg::OP_WRITE)
				mem[word_index] <= mem_bus.wdata;
			mem_bus.rdata <= mem[word_index];
		end
	end

endmodule

// ==== logic/led_port.sv ====
`timescale 1ns/1ps

module led_port
(
	input logic clock,
	input logic i_rst_n,
	soc_bus_if.slave reg_bus,
	output logic [soc_pkg::LED_W-1:0] o_ledr
);

	logic access;

	assign access = reg_bus.request && !reg_bus.ready;

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			reg_bus.ready <= 1'b0;
			o_ledr <= '0;
		end
		else
		begin
			reg_bus.ready <= access;
			// Only the low bits reach the LEDs
			if (access && reg_bus.rw == soc_pkg::OP_WRITE)
				o_ledr <= reg_bus.wdata[soc_pkg::LED_W-1:0];
		end
	end

	// Write only register
	assign reg_bus.rdata = '0;

endmodule

// ==== logic/cycle_timer.sv ====
`timescale 1ns/1ps

module cycle_timer
(
	input logic clock,
	input logic i_rst_n,
	soc_bus_if.slave reg_bus
);

	localparam int COUNT_W = 2 * soc_pkg::DATA_W;

	logic [COUNT_W-1:0] count;
	logic access;
	logic high_word;

	assign access = reg_bus.request && !reg_bus.ready;

	// Word 1 holds the upper half
	assign high_word = reg_bus.address[soc_pkg::WORD_LSB];

	// Free running cycle count
	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	always_ff @(posedge clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			reg_bus.ready <= 1'b0;
		else
			reg_bus.ready <= access;
	end

	// Sampled together with ready, writes just get acknowledged
	always_ff @(posedge clock)
	begin
		if (access)
		begin
			if (high_word)
				reg_bus.rdata <= count[COUNT_W-1:soc_pkg::DATA_W];
			else
				reg_bus.rdata <= count[soc_pkg::DATA_W-1:0];
		end
	end

endmodule

// ==== logic/soc_top.sv ====
`timescale 1ns/1ps

module soc_top
(
	input logic clock,
	input logic i_rst_n,

	// Instruction port
	input logic i_ia_request,
	input logic [soc_pkg::ADDR_W-1:0] i_ia_address,
	output logic o_ia_ready,
	output logic [soc_pkg::DATA_W-1:0] o_ia_rdata,

	// Data port
	input logic i_db_request,
	input soc_pkg::bus_op_e i_db_rw,
	input logic [soc_pkg::ADDR_W-1:0] i_db_address,
	input logic [soc_pkg::DATA_W-1:0] i_db_wdata,
	output logic o_db_ready,
	output logic [soc_pkg::DATA_W-1:0] o_db_rdata,

	output logic [soc_pkg::LED_W-1:0] o_ledr
);

	soc_bus_if sys_bus ();
	soc_bus_if ram_bus ();
	soc_bus_if led_bus ();
	soc_bus_if timer_bus ();

	// ==================================================================
	// Masters onto the shared bus
	// ==================================================================

	bus_access bus_access_inst
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_ia_request(i_ia_request),
		.i_ia_address(i_ia_address),
		.o_ia_ready(o_ia_ready),
		.o_ia_rdata(o_ia_rdata),
		.i_db_request(i_db_request),
		.i_db_rw(i_db_rw),
		.i_db_address(i_db_address),
		.i_db_wdata(i_db_wdata),
		.o_db_ready(o_db_ready),
		.o_db_rdata(o_db_rdata),
		.sys_bus(sys_bus.master)
	);

	bus_decoder bus_decoder_inst
	(
		.sys_bus(sys_bus.slave),
		.ram_bus(ram_bus.master),
		.led_bus(led_bus.master),
		.timer_bus(timer_bus.master)
	);

	// ==================================================================
	// Slaves
	// ==================================================================

	block_ram block_ram_inst
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.mem_bus(ram_bus.slave)
	);

	led_port led_port_inst
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.reg_bus(led_bus.slave),
		.o_ledr(o_ledr)
	);

	cycle_timer cycle_timer_inst
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.reg_bus(timer_bus.slave)
	);

endmodule

// ==== dv/tb_soc.sv ====
`timescale 1ns/1ps

module tb_soc;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int RAM_TESTS = 8;
	localparam int TIMER_GAP = 20;
	localparam logic [31:0] RAND_SEED = 32'hb24a;
	localparam logic [soc_pkg::ADDR_W-1:0] UNMAPPED_ADDR = 32'h3000_0000;

	// Reset, about 30 transfers of under 10 cycles each and the timer gap,
	// rounded up generously
	localparam int MAX_CYCLES = 2000;

	logic clock;
	logic i_rst_n;
	logic i_ia_request;
	logic [soc_pkg::ADDR_W-1:0] i_ia_address;
	logic o_ia_ready;
	logic [soc_pkg::DATA_W-1:0] o_ia_rdata;
	logic i_db_request;
	soc_pkg::bus_op_e i_db_rw;
	logic [soc_pkg::ADDR_W-1:0] i_db_address;
	logic [soc_pkg::DATA_W-1:0] i_db_wdata;
	logic o_db_ready;
	logic [soc_pkg::DATA_W-1:0] o_db_rdata;
	logic [soc_pkg::LED_W-1:0] o_ledr;

	// Expected RAM contents and the word indices written so far
	logic [soc_pkg::DATA_W-1:0] ram_model [soc_pkg::RAM_WORDS];
	int written_idx [$];

	string test_name;
	int test_errors = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;
	int ia_ready_count = 0;
	int db_ready_count = 0;
	int ia_done_cycle = 0;
	int db_done_cycle = 0;

	soc_top soc_top_inst
	(
		.clock(clock),
		.i_rst_n(i_rst_n),
		.i_ia_request(i_ia_request),
		.i_ia_address(i_ia_address),
		.o_ia_ready(o_ia_ready),
		.o_ia_rdata(o_ia_rdata),
		.i_db_request(i_db_request),
		.i_db_rw(i_db_rw),
		.i_db_address(i_db_address),
		.i_db_wdata(i_db_wdata),
		.o_db_ready(o_db_ready),
		.o_db_rdata(o_db_rdata),
		.o_ledr(o_ledr)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#(CLK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	// Ready pulses per port, sampled mid-cycle
	always @(negedge clock)
	begin
		if (o_ia_ready)
			ia_ready_count = ia_ready_count + 1;
		if (o_db_ready)
			db_ready_count = db_ready_count + 1;
	end

	// ==================================================================
	// Bus tasks, entered and left 1 ns after a rising edge
	// ==================================================================

	function automatic logic [soc_pkg::ADDR_W-1:0] ram_address(input int idx);
		return soc_pkg::RAM_BASE + (idx << soc_pkg::WORD_LSB);
	endfunction

	task automatic db_transfer
	(
		input soc_pkg::bus_op_e rw,
		input logic [soc_pkg::ADDR_W-1:0] address,
		input logic [soc_pkg::DATA_W-1:0] wdata,
		output logic [soc_pkg::DATA_W-1:0] rdata
	);
		i_db_request = 1'b1;
		i_db_rw = rw;
		i_db_address = address;
		i_db_wdata = wdata;
		@(negedge clock);
		while (!o_db_ready)
			@(negedge clock);
		rdata = o_db_rdata;
		db_done_cycle = cycle_count;
		@(posedge clock);
		#1;
		i_db_request = 1'b0;
	endtask

	task automatic db_write
	(
		input logic [soc_pkg::ADDR_W-1:0] address,
		input logic [soc_pkg::DATA_W-1:0] wdata
	);
		logic [soc_pkg::DATA_W-1:0] unused;
		db_transfer(soc_pkg::OP_WRITE, address, wdata, unused);
	endtask

	task automatic db_read
	(
		input logic [soc_pkg::ADDR_W-1:0] address,
		output logic [soc_pkg::DATA_W-1:0] rdata
	);
		db_transfer(soc_pkg::OP_READ, address, '0, rdata);
	endtask

	task automatic ia_read
	(
		input logic [soc_pkg::ADDR_W-1:0] address,
		output logic [soc_pkg::DATA_W-1:0] rdata
	);
		i_ia_request = 1'b1;
		i_ia_address = address;
		@(negedge clock);
		while (!o_ia_ready)
			@(negedge clock);
		rdata = o_ia_rdata;
		ia_done_cycle = cycle_count;
		@(posedge clock);
		#1;
		i_ia_request = 1'b0;
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
			@(posedge clock);
		#1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		if (test_errors == 0)
		begin
			pass_count++;
			$display("%s: ok", test_name);
		end
		else
		begin
			fail_count++;
			$display("%s: %0d errors", test_name, test_errors);
		end
	endtask

	task automatic report_mismatch
	(
		input string what,
		input logic [soc_pkg::DATA_W-1:0] expected,
		input logic [soc_pkg::DATA_W-1:0] actual
	);
		$display("Error in %s: %s expected %h actual %h", test_name, what, expected, actual);
		test_errors++;
	endtask

	// ==================================================================
	// Tests
	// ==================================================================

	task automatic reset_state();
		start_test("reset_state");
		if (o_ia_ready !== 1'b0)
			report_mismatch("o_ia_ready", 0, o_ia_ready);
		if (o_db_ready !== 1'b0)
			report_mismatch("o_db_ready", 0, o_db_ready);
		if (o_ledr !== '0)
			report_mismatch("o_ledr", 0, o_ledr);
		finish_test();
	endtask

	task automatic ram_data_port();
		int idx;
		logic [soc_pkg::DATA_W-1:0] data;
		start_test("ram_data_port");
		for (int i = 0; i < RAM_TESTS; i++)
		begin
			idx = $urandom % soc_pkg::RAM_WORDS;
			data = $urandom;
			db_write(ram_address(idx), data);
			ram_model[idx] = data;
			written_idx.push_back(idx);
		end
		// Later writes to a repeated index win in the model too
		foreach (written_idx[i])
		begin
			db_read(ram_address(written_idx[i]), data);
			if (data !== ram_model[written_idx[i]])
				report_mismatch("RAM read", ram_model[written_idx[i]], data);
		end
		finish_test();
	endtask

	task automatic ram_instr_port();
		logic [soc_pkg::DATA_W-1:0] data;
		start_test("ram_instr_port");
		foreach (written_idx[i])
		begin
			ia_read(ram_address(written_idx[i]), data);
			if (data !== ram_model[written_idx[i]])
				report_mismatch("instruction read", ram_model[written_idx[i]], data);
		end
		finish_test();
	endtask

	task automatic port_contention();
		int ia_idx;
		int db_idx;
		int ia_before;
		int db_before;
		logic [soc_pkg::DATA_W-1:0] wdata;
		logic [soc_pkg::DATA_W-1:0] ia_data;
		logic [soc_pkg::DATA_W-1:0] db_data;
		start_test("port_contention");
		ia_idx = written_idx[0];
		do
			db_idx = $urandom % soc_pkg::RAM_WORDS;
		while (db_idx == ia_idx);
		wdata = $urandom;
		ia_before = ia_ready_count;
		db_before = db_ready_count;
		fork
			db_write(ram_address(db_idx), wdata);
			ia_read(ram_address(ia_idx), ia_data);
		join
		ram_model[db_idx] = wdata;
		written_idx.push_back(db_idx);
		idle_cycles(2);
		if (ia_ready_count - ia_before != 1)
			report_mismatch("instruction ready pulses", 1, ia_ready_count - ia_before);
		if (db_ready_count - db_before != 1)
			report_mismatch("data ready pulses", 1, db_ready_count - db_before);
		if (ia_data !== ram_model[ia_idx])
			report_mismatch("instruction read", ram_model[ia_idx], ia_data);
		if (db_done_cycle >= ia_done_cycle)
		begin
			$display("Error in %s: data port ready did not come before instruction port ready",
				test_name);
			test_errors++;
		end
		db_read(ram_address(db_idx), db_data);
		if (db_data !== wdata)
			report_mismatch("read of contended write", wdata, db_data);
		finish_test();
	endtask

	task automatic led_register();
		logic [soc_pkg::DATA_W-1:0] wdata;
		logic [soc_pkg::DATA_W-1:0] rdata;
		start_test("led_register");
		wdata = $urandom;
		db_write(soc_pkg::LED_BASE, wdata);
		if (o_ledr !== wdata[soc_pkg::LED_W-1:0])
			report_mismatch("o_ledr", wdata[soc_pkg::LED_W-1:0], o_ledr);
		db_read(soc_pkg::LED_BASE, rdata);
		if (rdata !== '0)
			report_mismatch("LED read", 0, rdata);
		finish_test();
	endtask

	task automatic timer_and_unmapped();
		logic [soc_pkg::DATA_W-1:0] first;
		logic [soc_pkg::DATA_W-1:0] second;
		logic [soc_pkg::DATA_W-1:0] rdata;
		start_test("timer_and_unmapped");
		db_read(soc_pkg::TIMER_BASE, first);
		idle_cycles(TIMER_GAP);
		db_read(soc_pkg::TIMER_BASE, second);
		if (second - first < TIMER_GAP)
		begin
			$display("Error in %s: timer advanced by %0d, expected at least %0d",
				test_name, second - first, TIMER_GAP);
			test_errors++;
		end
		db_read(soc_pkg::TIMER_BASE + 4, rdata);
		if (rdata !== '0)
			report_mismatch("timer word 1", 0, rdata);
		db_read(UNMAPPED_ADDR, rdata);
		if (rdata !== '0)
			report_mismatch("unmapped read", 0, rdata);
		finish_test();
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================

	initial
	begin
		void'($urandom(RAND_SEED));
		i_rst_n = 1'b0;
		i_ia_request = 1'b0;
		i_ia_address = '0;
		i_db_request = 1'b0;
		i_db_rw = soc_pkg::OP_READ;
		i_db_address = '0;
		i_db_wdata = '0;
		idle_cycles(RESET_CYCLES);
		i_rst_n = 1'b1;
		idle_cycles(2);

		reset_state();
		ram_data_port();
		ram_instr_port();
		port_contention();
		led_register();
		timer_and_unmapped();

		$display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
logic/soc_pkg.sv
logic/soc_bus_if.sv
logic/bus_access.sv
logic/bus_decoder.sv
logic/block_ram.sv
logic/led_port.sv
logic/cycle_timer.sv
logic/soc_top.sv
dv/tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_bus

dependencies: {}

sources:
  # RTL in compile order
  - logic/soc_pkg.sv
  - logic/soc_bus_if.sv
  - logic/bus_access.sv
  - logic/bus_decoder.sv
  - logic/block_ram.sv
  - logic/led_port.sv
  - logic/cycle_timer.sv
  - logic/soc_top.sv

  # Testbench
  - target: test
    files:
      - dv/tb_soc.sv
